/* build.f */
hw/cu_pkg.sv
hw/cu_decode.sv
hw/cu_seq.sv
hw/cu_ctrl_rom.sv
hw/control_unit.sv
tests/control_unit_chk.sv
tests/control_unit_tb.sv

/* hw/control_unit.sv */
// Multicycle controller of the accumulator CPU
// Decoder, sequencer and registered control-word stage
module control_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  cu_pkg::instr_t       ir,         // From the datapath IR
    input  logic                 mem_ready,
    output cu_pkg::ctrl_word_t   ctrl
);

    cu_pkg::op_class_t            op_class;
    logic [cu_pkg::STEP_W-1:0]    exec_len;
    cu_pkg::phase_t               phase;
    logic [cu_pkg::STEP_W-1:0]    step;

    cu_decode decode_i (
        .ir       (ir),
        .op_class (op_class),
        .exec_len (exec_len)
    );

    cu_seq seq_i (
        .clk       (clk),
        .reset     (reset),
        .mem_ready (mem_ready),
        .exec_len  (exec_len),
        .phase     (phase),
        .step      (step)
    );

    cu_ctrl_rom rom_i (
        .clk       (clk),
        .reset     (reset),
        .phase     (phase),
        .step      (step),
        .op_class  (op_class),
        .mem_ready (mem_ready),
        .ctrl      (ctrl)
    );

endmodule

/* hw/cu_ctrl_rom.sv */
// Control word table
// Looks up the word for phase, class and step and registers it onto ctrl
module cu_ctrl_rom (
    input  logic                        clk,
    input  logic                        reset,
    input  cu_pkg::phase_t              phase,
    input  logic [cu_pkg::STEP_W-1:0]   step,
    input  cu_pkg::op_class_t           op_class,
    input  logic                        mem_ready,
    output cu_pkg::ctrl_word_t          ctrl
);

    cu_pkg::ctrl_word_t word;

    // ------------------------------
    // Table lookup
    // ------------------------------
    always_comb begin
        word = cu_pkg::CTRL_IDLE;

        case (phase)
            cu_pkg::PH_FETCH: begin
                case (step)
                    3'd0: begin
                        word.bus_sel = cu_pkg::BUS_PC;  // AR <- PC
                        word.ar_load = 1'b1;
                    end
                    3'd1: word.pc_inc = 1'b1;
                    3'd2: begin
                        // IR load only once memory data is valid
                        if (mem_ready) begin
                            word.bus_sel = cu_pkg::BUS_MEM;
                            word.ir_load = 1'b1;
                        end
                    end
                    default: word = cu_pkg::CTRL_IDLE;
                endcase
            end

            cu_pkg::PH_EXEC: begin
                case (op_class)
                    cu_pkg::CLS_LDA, cu_pkg::CLS_ADD, cu_pkg::CLS_SUB: begin
                        // Same operand fetch, they differ in the ALU op
                        case (step)
                            3'd0: begin
                                word.bus_sel = cu_pkg::BUS_IR_ADDR;
                                word.ar_load = 1'b1;
                            end
                            3'd2: begin
                                word.bus_sel = cu_pkg::BUS_MEM;  // DR <- M[AR]
                                word.dr_load = 1'b1;
                            end
                            3'd3: begin
                                word.ac_load = 1'b1;
                                if (op_class == cu_pkg::CLS_LDA) begin
                                    word.alu_sel = cu_pkg::ALU_PASS;
                                end else if (op_class == cu_pkg::CLS_SUB) begin
                                    word.alu_sel = cu_pkg::ALU_SUB;
                                end else begin
                                    word.alu_sel = cu_pkg::ALU_ADD;
                                end
                            end
                            default: word = cu_pkg::CTRL_IDLE;  // Steps 1 and 4
                        endcase
                    end

                    cu_pkg::CLS_STA: begin
                        case (step)
                            3'd0: begin
                                word.bus_sel = cu_pkg::BUS_IR_ADDR;
                                word.ar_load = 1'b1;
                            end
                            3'd1: begin
                                word.bus_sel = cu_pkg::BUS_AC;  // DR <- AC
                                word.dr_load = 1'b1;
                            end
                            3'd2: word.write_en = 1'b1;
                            default: word = cu_pkg::CTRL_IDLE;
                        endcase
                    end

                    cu_pkg::CLS_BUN: begin
                        if (step == 3'd0) begin
                            word.bus_sel = cu_pkg::BUS_IR_ADDR;  // PC <- target
                            word.pc_load = 1'b1;
                        end
                    end

                    default: word = cu_pkg::CTRL_IDLE;
                endcase
            end

            default: word = cu_pkg::CTRL_IDLE;  // Decode cycle
        endcase
    end

    // Output register, one cycle behind the sequencer
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= cu_pkg::CTRL_IDLE;
        end else begin
            ctrl <= word;
        end
    end

endmodule

/* hw/cu_decode.sv */
// Opcode decoder
// Maps the IR opcode field to an operation class and execute length
module cu_decode (
    input  cu_pkg::instr_t              ir,
    output cu_pkg::op_class_t           op_class,
    output logic [cu_pkg::STEP_W-1:0]   exec_len
);

    always_comb begin
        // Only the 8-bit opcode field takes part, the address is ignored
        case (ir.opcode)
            cu_pkg::OP_LDA: begin
                op_class = cu_pkg::CLS_LDA;
                exec_len = cu_pkg::LEN_LDA;
            end
            cu_pkg::OP_STA: begin
                op_class = cu_pkg::CLS_STA;
                exec_len = cu_pkg::LEN_STA;
            end
            cu_pkg::OP_ADD: begin
                op_class = cu_pkg::CLS_ADD;
                exec_len = cu_pkg::LEN_ADD;
            end
            cu_pkg::OP_SUB: begin
                op_class = cu_pkg::CLS_SUB;
                exec_len = cu_pkg::LEN_SUB;
            end
            cu_pkg::OP_BUN: begin
                op_class = cu_pkg::CLS_BUN;
                exec_len = cu_pkg::LEN_BUN;
            end
            default: begin
                // Unknown opcode, decode returns straight to fetch
                op_class = cu_pkg::CLS_NOP;
                exec_len = cu_pkg::LEN_NOP;
            end
        endcase
    end

endmodule

/* hw/cu_pkg.sv */
// Shared definitions for the accumulator CPU control unit
// Instruction format, opcodes, sequencer phases and the control word
package cu_pkg;

    // ------------------------------
    // Instruction word
    // ------------------------------
    typedef struct packed {
        logic [7:0] opcode;  // Bits 15..8
        logic [7:0] addr;    // Operand address
    } instr_t;

    // Kept opcodes, everything else runs as a no-op
    localparam logic [7:0] OP_LDA = 8'h00;
    localparam logic [7:0] OP_STA = 8'h01;
    localparam logic [7:0] OP_ADD = 8'h10;
    localparam logic [7:0] OP_SUB = 8'h11;
    localparam logic [7:0] OP_BUN = 8'h20;  // Unconditional jump

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_LDA,
        CLS_STA,
        CLS_ADD,
        CLS_SUB,
        CLS_BUN
    } op_class_t;

    // ------------------------------
    // Sequencer
    // ------------------------------
    typedef enum logic [1:0] {
        PH_FETCH,
        PH_DECODE,
        PH_EXEC
    } phase_t;

    localparam int STEP_W = 3;

    localparam logic [STEP_W-1:0] FETCH_STEPS = 3'd3;
    localparam logic [STEP_W-1:0] LEN_LDA     = 3'd4;
    localparam logic [STEP_W-1:0] LEN_STA     = 3'd4;
    localparam logic [STEP_W-1:0] LEN_ADD     = 3'd5;
    localparam logic [STEP_W-1:0] LEN_SUB     = 3'd5;
    localparam logic [STEP_W-1:0] LEN_BUN     = 3'd2;
    localparam logic [STEP_W-1:0] LEN_NOP     = 3'd0;  // Skip execute

    // ------------------------------
    // Control word
    // ------------------------------
    typedef enum logic [1:0] {
        BUS_IR_ADDR = 2'b00,  // Address field of IR
        BUS_AC      = 2'b01,
        BUS_MEM     = 2'b10,
        BUS_PC      = 2'b11
    } bus_src_t;

    typedef enum logic [1:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB
    } alu_op_t;

    typedef struct packed {
        logic     ar_load;
        logic     dr_load;
        logic     ac_load;
        logic     ir_load;
        logic     pc_inc;
        logic     pc_load;
        logic     write_en;
        bus_src_t bus_sel;
        alu_op_t  alu_sel;
    } ctrl_word_t;

    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

/* hw/cu_seq.sv */
// Instruction sequencer
// Phase and step counter through fetch, decode and execute
module cu_seq (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mem_ready,
    input  logic [cu_pkg::STEP_W-1:0]   exec_len,
    output cu_pkg::phase_t              phase,
    output logic [cu_pkg::STEP_W-1:0]   step
);

    cu_pkg::phase_t              phase_next;
    logic [cu_pkg::STEP_W-1:0]   step_next;
    logic [cu_pkg::STEP_W-1:0]   step_inc;
    logic                        fetch_last;
    logic                        exec_last;

    assign step_inc   = step + 1'b1;
    assign fetch_last = (step_inc == cu_pkg::FETCH_STEPS);
    assign exec_last  = (step_inc == exec_len);

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        phase_next = phase;
        step_next  = step_inc;

        case (phase)
            cu_pkg::PH_FETCH: begin
                if (fetch_last) begin
                    if (mem_ready) begin
                        phase_next = cu_pkg::PH_DECODE;
                        step_next  = '0;
                    end else begin
                        step_next = step;  // Hold until memory answers
                    end
                end
            end

            cu_pkg::PH_DECODE: begin
                step_next = '0;
                if (exec_len == '0) begin
                    phase_next = cu_pkg::PH_FETCH;  // No-op, nothing to execute
                end else begin
                    phase_next = cu_pkg::PH_EXEC;
                end
            end

            cu_pkg::PH_EXEC: begin
                if (exec_last) begin
                    phase_next = cu_pkg::PH_FETCH;
                    step_next  = '0;
                end
            end

            default: begin
                // Unused phase code, recover into fetch
                phase_next = cu_pkg::PH_FETCH;
                step_next  = '0;
            end
        endcase
    end

    // ------------------------------
    // State registers
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= cu_pkg::PH_FETCH;
            step  <= '0;
        end else begin
            phase <= phase_next;
            step  <= step_next;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module control_unit_tb -Mdir obj_dir -o sim_control_unit \
    -f build.f

./obj_dir/sim_control_unit 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi

/* tests/control_unit_chk.sv */
// Bound checker for the control unit
// Flags illegal combinations on the registered control word
module control_unit_chk (
    input logic               clk,
    input logic               reset,
    input cu_pkg::ctrl_word_t ctrl
);
    timeunit 1ns;
    timeprecision 1ps;

    logic any_load;

    assign any_load = ctrl.ar_load | ctrl.dr_load | ctrl.ac_load | ctrl.ir_load
                    | ctrl.pc_inc | ctrl.pc_load;

    // PC either counts or jumps
    pc_update_excl: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pc_inc && ctrl.pc_load))
        else $error("pc_inc and pc_load are high together");

    ir_from_mem: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_load |-> ctrl.bus_sel == cu_pkg::BUS_MEM)
        else $error("ir_load without the memory on the bus");

    write_alone: assert property (@(posedge clk) disable iff (reset)
        ctrl.write_en |-> !any_load)  // Memory write cycle loads nothing
        else $error("write_en together with a register load");

    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> ctrl == cu_pkg::CTRL_IDLE)
        else $error("ctrl is not idle in the first cycle after reset");

endmodule

bind control_unit control_unit_chk chk_i (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl)
);

/* tests/control_unit_tb.sv */
// Testbench for the control unit
// Directed and random instruction streams checked against a reference model
module control_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int INSTR_TIMEOUT = 200;  // Cycles per instruction

    logic               clk;
    logic               reset;
    cu_pkg::instr_t     ir;
    logic               mem_ready;
    cu_pkg::ctrl_word_t ctrl;
    logic [31:0]        lcg_state;
    cu_pkg::phase_t     t_phase;     // Reference sequencer
    int                 t_step;
    cu_pkg::ctrl_word_t exp_word;

    control_unit dut_i (
        .clk       (clk),
        .reset     (reset),
        .ir        (ir),
        .mem_ready (mem_ready),
        .ctrl      (ctrl)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int length_of(input logic [7:0] op);
        case (op)
            cu_pkg::OP_LDA: return int'(cu_pkg::LEN_LDA);
            cu_pkg::OP_STA: return int'(cu_pkg::LEN_STA);
            cu_pkg::OP_ADD: return int'(cu_pkg::LEN_ADD);
            cu_pkg::OP_SUB: return int'(cu_pkg::LEN_SUB);
            cu_pkg::OP_BUN: return int'(cu_pkg::LEN_BUN);
            default: return 0;
        endcase
    endfunction

    function automatic cu_pkg::ctrl_word_t expected_word(input cu_pkg::phase_t ph,
            input int stp, input logic [7:0] op, input logic rdy);
        cu_pkg::ctrl_word_t w;
        w = cu_pkg::CTRL_IDLE;
        if (ph == cu_pkg::PH_FETCH) begin
            w.ar_load = (stp == 0);
            w.pc_inc  = (stp == 1);
            w.ir_load = (stp == 2) && rdy;
            if (stp == 0) w.bus_sel = cu_pkg::BUS_PC;
            if (w.ir_load) w.bus_sel = cu_pkg::BUS_MEM;
        end else if (ph == cu_pkg::PH_EXEC) begin
            w.ar_load  = (stp == 0) && op != cu_pkg::OP_BUN;
            w.pc_load  = (stp == 0) && op == cu_pkg::OP_BUN;
            w.write_en = (stp == 2) && op == cu_pkg::OP_STA;
            w.dr_load  = (op == cu_pkg::OP_STA) ? (stp == 1) : (stp == 2);
            w.ac_load  = (stp == 3) && op != cu_pkg::OP_STA;
            if (w.dr_load) begin
                w.bus_sel = (op == cu_pkg::OP_STA) ? cu_pkg::BUS_AC : cu_pkg::BUS_MEM;
            end
            if (w.ac_load && op == cu_pkg::OP_ADD) w.alu_sel = cu_pkg::ALU_ADD;
            if (w.ac_load && op == cu_pkg::OP_SUB) w.alu_sel = cu_pkg::ALU_SUB;
        end
        return w;
    endfunction

    // Fetch step 0 is the only word that puts the PC on the bus
    function automatic bit is_fetch_start(input cu_pkg::ctrl_word_t w);
        return w.ar_load && w.bus_sel == cu_pkg::BUS_PC;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------
    // Reference tracker and comparer
    // ------------------------------
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            t_phase  <= cu_pkg::PH_FETCH;
            t_step   <= 0;
            exp_word <= cu_pkg::CTRL_IDLE;
        end else begin
            exp_word <= expected_word(t_phase, t_step, ir.opcode, mem_ready);
            t_step   <= t_step + 1;
            if (t_phase == cu_pkg::PH_FETCH && t_step == 2) begin
                t_step <= mem_ready ? 0 : 2;  // Wait for memory
                if (mem_ready) t_phase <= cu_pkg::PH_DECODE;
            end else if (t_phase == cu_pkg::PH_DECODE) begin
                t_step <= 0;
                if (length_of(ir.opcode) == 0) t_phase <= cu_pkg::PH_FETCH;
                else t_phase <= cu_pkg::PH_EXEC;
            end else if (t_phase == cu_pkg::PH_EXEC && t_step == length_of(ir.opcode) - 1) begin
                t_phase <= cu_pkg::PH_FETCH;
                t_step  <= 0;
            end
        end
    end

    always @(negedge clk) begin
        assert (ctrl === exp_word) else begin
            abort_run($sformatf("Mismatch ctrl: expected %h actual %h", exp_word, ctrl));
        end
    end

    task automatic wait_fetch_start();
        int cycles;
        cycles = 0;
        while (!is_fetch_start(ctrl) && cycles < INSTR_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!is_fetch_start(ctrl)) begin
            abort_run("Timeout: no fetch word appeared after reset");
        end
    endtask

    // Starts at a falling edge where ctrl shows the fetch step 0 word
    // A negative stall picks mem_ready at random
    task automatic run_instr(input logic [7:0] op, input logic [7:0] addr, input int stall);
        logic [31:0] rnd;
        int          cycles;
        bit          done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < INSTR_TIMEOUT) begin
            @(posedge clk);
            if (cycles == 0) begin
                ir.opcode <= op;
                ir.addr   <= addr;
            end
            rnd = lcg_next();
            if (stall >= 0) mem_ready <= (cycles >= stall);
            else mem_ready <= (rnd[31:16] % 16'd3) != 16'd0;  // Low about one in three
            cycles++;
            @(negedge clk);
            done = is_fetch_start(ctrl);
        end
        if (!done) begin
            abort_run($sformatf("Timeout: opcode %h never returned to fetch", op));
        end else if (stall >= 0) begin
            assert (cycles == 4 + length_of(op) + stall) else begin
                abort_run($sformatf("Mismatch cycles: opcode %h expected %h actual %h",
                                    op, 4 + length_of(op) + stall, cycles));
            end
        end
    endtask

    task automatic run_random_stream(input int count);
        logic [31:0] rnd;
        logic [7:0]  op;
        for (int i = 0; i < count; i++) begin
            rnd = lcg_next();
            case (rnd[30:28])
                3'd0: op = cu_pkg::OP_LDA;
                3'd1: op = cu_pkg::OP_STA;
                3'd2: op = cu_pkg::OP_ADD;
                3'd3: op = cu_pkg::OP_SUB;
                3'd4: op = cu_pkg::OP_BUN;
                default: op = rnd[23:16];  // Mostly unknown opcodes
            endcase
            run_instr(op, rnd[15:8], -1);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        ir        = '0;
        mem_ready = 1'b0;
        lcg_state = 32'h2644a18c;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_fetch_start();
        run_instr(cu_pkg::OP_LDA, 8'h12, 0);
        run_instr(cu_pkg::OP_STA, 8'h34, 0);
        run_instr(cu_pkg::OP_ADD, 8'h56, 0);
        run_instr(cu_pkg::OP_SUB, 8'h78, 0);
        run_instr(cu_pkg::OP_BUN, 8'h9a, 0);
        run_instr(8'h5c, 8'hbc, 0);  // Unknown opcode
        run_instr(cu_pkg::OP_ADD, 8'h0f, 3);
        run_instr(cu_pkg::OP_STA, 8'hf0, 1);
        run_random_stream(400);
        $display("STATUS: PASS");
        $finish;
    end

endmodule
